/* include/cp0_consts.svh */
`ifndef CP0_CONSTS_SVH
`define CP0_CONSTS_SVH

`define CP0_TLB_ENTRIES 16
`define CP0_TLB_IDX_W 4

`define CP0_REG_INDEX 5'd0
`define CP0_REG_RANDOM 5'd1
`define CP0_REG_ENTRY_LO0 5'd2
`define CP0_REG_ENTRY_LO1 5'd3
`define CP0_REG_CONTEXT 5'd4
`define CP0_REG_WIRED 5'd6
`define CP0_REG_BAD_VADDR 5'd8
`define CP0_REG_COUNT 5'd9
`define CP0_REG_ENTRY_HI 5'd10
`define CP0_REG_COMPARE 5'd11
`define CP0_REG_STATUS 5'd12
`define CP0_REG_CAUSE 5'd13
`define CP0_REG_EPC 5'd14
`define CP0_REG_PRID 5'd15
`define CP0_REG_CONFIG0 5'd16

`define CP0_EXC_ADEL 5'd4
`define CP0_EXC_ADES 5'd5
`define CP0_EXC_TLBL 5'd2
`define CP0_EXC_TLBS 5'd3

`define CP0_STATUS_RESET 32'h0040_0004
`define CP0_PRID_VALUE 32'h0001_8000
`define CP0_CONFIG0_RESET 32'h8000_0083

`endif

/* logic/cp0_pkg.sv */
package cp0_pkg;

	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [2:0] pad_31_29;
			logic       cu0;
			logic [4:0] pad_27_23;
			logic       bev;
			logic [5:0] pad_21_16;
			logic [7:0] im;
			logic [2:0] pad_7_5;
			logic       um;
			logic       pad_3;
			logic       erl;
			logic       exl;
			logic       ie;
		} fields;
	} cp0_status_u;

	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic       bd;
			logic [6:0] pad_30_24;
			logic       iv;
			logic [6:0] pad_22_16;
			logic [7:0] ip;
			logic       pad_7;
			logic [4:0] exc_code;
			logic [1:0] pad_1_0;
		} fields;
	} cp0_cause_u;

endpackage

/* logic/cp0_access_ctrl.sv */
`timescale 1ns/100ps
`include "cp0_consts.svh"

module cp0_access_ctrl import cp0_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        stall,
	input  logic        we,
	input  logic [4:0]  waddr,
	input  logic [2:0]  wsel,
	input  logic [31:0] wdata_in,
	input  logic [4:0]  raddr,
	input  logic [2:0]  rsel,
	input  logic        except_valid,
	input  logic        except_eret,
	input  logic [4:0]  except_code,
	input  logic        tlbr_req,
	input  logic        tlbp_req,
	input  logic [31:0] index,
	input  logic [31:0] random,
	input  logic [31:0] entry_lo0,
	input  logic [31:0] entry_lo1,
	input  logic [31:0] context_word,
	input  logic [31:0] wired,
	input  logic [31:0] bad_vaddr,
	input  logic [31:0] count,
	input  logic [31:0] entry_hi,
	input  logic [31:0] compare,
	input  logic [31:0] epc,
	input  cp0_status_u status,
	input  cp0_cause_u  cause,
	output logic        index_we,
	output logic        entry_lo0_we,
	output logic        entry_lo1_we,
	output logic        context_we,
	output logic        wired_we,
	output logic        count_we,
	output logic        entry_hi_we,
	output logic        compare_we,
	output logic        status_we,
	output logic        cause_we,
	output logic        epc_we,
	output logic        except_take,
	output logic        eret_take,
	output logic        badvaddr_load,
	output logic        tlb_fault_load,
	output logic        tlbr_take,
	output logic        tlbp_take,
	output logic [31:0] wdata,
	output logic [31:0] rdata,
	output logic        kseg0_uncached
);

	logic        mtc0_ok;
	logic        addr_err;
	logic        tlb_fault;
	logic        config0_we;
	logic [31:0] config0;
	logic [31:0] rdata_d;

	assign mtc0_ok = we && !stall && (wsel == 3'd0); // Only sel 0 is implemented
	assign wdata = wdata_in;

	assign except_take = except_valid && !except_eret;
	assign eret_take = except_valid && except_eret;
	assign addr_err = (except_code == `CP0_EXC_ADEL) || (except_code == `CP0_EXC_ADES);
	assign tlb_fault = (except_code == `CP0_EXC_TLBL) || (except_code == `CP0_EXC_TLBS);
	assign badvaddr_load = except_take && (addr_err || tlb_fault);
	assign tlb_fault_load = except_take && tlb_fault;

	assign tlbr_take = tlbr_req && !stall;
	assign tlbp_take = tlbp_req && !stall;

	// MTC0 loses any register it shares with a TLB operation or an exception
	assign index_we = mtc0_ok && (waddr == `CP0_REG_INDEX) && !tlbp_take;
	assign entry_lo0_we = mtc0_ok && (waddr == `CP0_REG_ENTRY_LO0) && !tlbr_take;
	assign entry_lo1_we = mtc0_ok && (waddr == `CP0_REG_ENTRY_LO1) && !tlbr_take;
	assign context_we = mtc0_ok && (waddr == `CP0_REG_CONTEXT); // Disjoint from BadVPN2
	assign wired_we = mtc0_ok && (waddr == `CP0_REG_WIRED);
	assign count_we = mtc0_ok && (waddr == `CP0_REG_COUNT);
	assign entry_hi_we = mtc0_ok && (waddr == `CP0_REG_ENTRY_HI) && !tlbr_take
		&& !tlb_fault_load;
	assign compare_we = mtc0_ok && (waddr == `CP0_REG_COMPARE);
	assign status_we = mtc0_ok && (waddr == `CP0_REG_STATUS) && !except_valid;
	assign cause_we = mtc0_ok && (waddr == `CP0_REG_CAUSE) && !except_valid;
	assign epc_we = mtc0_ok && (waddr == `CP0_REG_EPC) && !except_valid;
	assign config0_we = mtc0_ok && (waddr == `CP0_REG_CONFIG0);

	always_ff @(posedge clk) begin
		if (rst) begin
			config0 <= `CP0_CONFIG0_RESET;
		end else if (config0_we) begin
			config0[2:0] <= wdata_in[2:0]; // K0 is the only writable field
		end
	end

	assign kseg0_uncached = (config0[2:0] == 3'd2);

	always_comb begin
		rdata_d = 32'd0;
		if (rsel == 3'd0) begin
			case (raddr)
				`CP0_REG_INDEX:     rdata_d = index;
				`CP0_REG_RANDOM:    rdata_d = random;
				`CP0_REG_ENTRY_LO0: rdata_d = entry_lo0;
				`CP0_REG_ENTRY_LO1: rdata_d = entry_lo1;
				`CP0_REG_CONTEXT:   rdata_d = context_word;
				`CP0_REG_WIRED:     rdata_d = wired;
				`CP0_REG_BAD_VADDR: rdata_d = bad_vaddr;
				`CP0_REG_COUNT:     rdata_d = count;
				`CP0_REG_ENTRY_HI:  rdata_d = entry_hi;
				`CP0_REG_COMPARE:   rdata_d = compare;
				`CP0_REG_STATUS:    rdata_d = status.raw;
				`CP0_REG_CAUSE:     rdata_d = cause.raw;
				`CP0_REG_EPC:       rdata_d = epc;
				`CP0_REG_PRID:      rdata_d = `CP0_PRID_VALUE;
				`CP0_REG_CONFIG0:   rdata_d = config0;
				default:            rdata_d = 32'd0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rdata <= 32'd0;
		end else begin
			rdata <= rdata_d;
		end
	end

endmodule

/* logic/cp0_status_cause.sv */
`timescale 1ns/100ps
`include "cp0_consts.svh"

module cp0_status_cause import cp0_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        status_we,
	input  logic        cause_we,
	input  logic        epc_we,
	input  logic        except_take,
	input  logic        eret_take,
	input  logic        badvaddr_load,
	input  logic        except_delayslot,
	input  logic [4:0]  except_code,
	input  logic [31:0] except_pc,
	input  logic [31:0] except_extra,
	input  logic [31:0] wdata,
	input  logic [7:0]  interrupt_flag,
	output cp0_status_u status,
	output cp0_cause_u  cause,
	output logic [31:0] epc,
	output logic [31:0] bad_vaddr,
	output logic        user_mode
);

	always_ff @(posedge clk) begin
		if (rst) begin
			status.raw <= `CP0_STATUS_RESET;
			cause.raw <= 32'd0;
			epc <= 32'd0;
			bad_vaddr <= 32'd0;
		end else begin
			cause.fields.ip[7:2] <= interrupt_flag[7:2]; // Hardware lines are sampled every cycle

			if (status_we) begin
				status.fields.cu0 <= wdata[28];
				status.fields.bev <= wdata[22];
				status.fields.im <= wdata[15:8];
				status.fields.um <= wdata[4];
				status.fields.erl <= wdata[2];
				status.fields.exl <= wdata[1];
				status.fields.ie <= wdata[0];
			end

			if (cause_we) begin
				cause.fields.iv <= wdata[23];
				cause.fields.ip[1:0] <= wdata[9:8]; // Software interrupts
			end

			if (epc_we) begin
				epc <= wdata;
			end

			if (except_take) begin
				// A nested exception keeps the EPC of the first one
				if (!status.fields.exl) begin
					epc <= except_delayslot ? except_pc - 32'd4 : except_pc;
					cause.fields.bd <= except_delayslot;
				end
				status.fields.exl <= 1'b1;
				cause.fields.exc_code <= except_code;
			end

			if (eret_take) begin
				if (status.fields.erl) begin
					status.fields.erl <= 1'b0;
				end else begin
					status.fields.exl <= 1'b0;
				end
			end

			if (badvaddr_load) begin
				bad_vaddr <= except_extra;
			end
		end
	end

	assign user_mode = status.fields.um && !status.fields.erl && !status.fields.exl;

endmodule

/* logic/cp0_timer.sv */
`timescale 1ns/100ps

module cp0_timer (
	input  logic        clk,
	input  logic        rst,
	input  logic        count_we,
	input  logic        compare_we,
	input  logic [31:0] wdata,
	output logic [31:0] count,
	output logic [31:0] compare,
	output logic        timer_int
);

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= 32'd0;
			compare <= 32'd0;
		end else begin
			count <= count_we ? wdata : count + 32'd1;
			if (compare_we) begin
				compare <= wdata;
			end
		end
	end

	// A zero Compare never raises the interrupt
	always_ff @(posedge clk) begin
		if (rst) begin
			timer_int <= 1'b0;
		end else if (compare != 32'd0 && compare == count) begin
			timer_int <= 1'b1;
		end else if (compare_we) begin
			timer_int <= 1'b0; // Acknowledge
		end
	end

endmodule

/* logic/cp0_tlb_regs.sv */
`timescale 1ns/100ps
`include "cp0_consts.svh"

module cp0_tlb_regs (
	input  logic        clk,
	input  logic        rst,
	input  logic        index_we,
	input  logic        entry_lo0_we,
	input  logic        entry_lo1_we,
	input  logic        context_we,
	input  logic        wired_we,
	input  logic        entry_hi_we,
	input  logic        tlbr_take,
	input  logic        tlbp_take,
	input  logic        tlbwr_req,
	input  logic        tlb_fault_load,
	input  logic [31:0] wdata,
	input  logic [31:0] except_extra,
	input  logic [31:0] tlbp_res,
	input  logic [18:0] tlbr_vpn2,
	input  logic [7:0]  tlbr_asid,
	input  logic        tlbr_g,
	input  logic [23:0] tlbr_pfn0,
	input  logic [2:0]  tlbr_c0,
	input  logic        tlbr_d0,
	input  logic        tlbr_v0,
	input  logic [23:0] tlbr_pfn1,
	input  logic [2:0]  tlbr_c1,
	input  logic        tlbr_d1,
	input  logic        tlbr_v1,
	output logic [31:0] index,
	output logic [31:0] random,
	output logic [31:0] entry_lo0,
	output logic [31:0] entry_lo1,
	output logic [31:0] context_word,
	output logic [31:0] wired,
	output logic [31:0] entry_hi,
	output logic [7:0]  asid,
	output logic [18:0] tlbw_vpn2,
	output logic [7:0]  tlbw_asid,
	output logic        tlbw_g,
	output logic [23:0] tlbw_pfn0,
	output logic [2:0]  tlbw_c0,
	output logic        tlbw_d0,
	output logic        tlbw_v0,
	output logic [23:0] tlbw_pfn1,
	output logic [2:0]  tlbw_c1,
	output logic        tlbw_d1,
	output logic        tlbw_v1
);

	localparam int IDX_W = `CP0_TLB_IDX_W;

	always_ff @(posedge clk) begin
		if (rst) begin
			index <= 32'd0;
			random <= `CP0_TLB_ENTRIES - 1;
			wired <= 32'd0;
			entry_lo0 <= 32'd0;
			entry_lo1 <= 32'd0;
			context_word <= 32'd0;
			entry_hi <= 32'd0;
		end else begin
			if (index_we) begin
				index[IDX_W-1:0] <= wdata[IDX_W-1:0];
			end else if (tlbp_take) begin
				index <= tlbp_res; // Probe result includes the P bit
			end

			if (wired_we) begin
				wired[IDX_W-1:0] <= wdata[IDX_W-1:0];
				random <= `CP0_TLB_ENTRIES - 1;
			end else if (tlbwr_req) begin
				if (&random[IDX_W-1:0]) begin
					random <= wired;
				end else begin
					random[IDX_W-1:0] <= random[IDX_W-1:0] + 1'b1;
				end
			end

			if (tlbr_take) begin
				entry_lo0 <= {2'b00, tlbr_pfn0, tlbr_c0, tlbr_d0, tlbr_v0, tlbr_g};
				entry_lo1 <= {2'b00, tlbr_pfn1, tlbr_c1, tlbr_d1, tlbr_v1, tlbr_g};
				entry_hi[31:13] <= tlbr_vpn2;
				entry_hi[7:0] <= tlbr_asid;
			end
			if (entry_lo0_we) begin
				entry_lo0 <= {2'b00, wdata[29:0]};
			end
			if (entry_lo1_we) begin
				entry_lo1 <= {2'b00, wdata[29:0]};
			end

			if (entry_hi_we) begin
				entry_hi[31:13] <= wdata[31:13];
				entry_hi[7:0] <= wdata[7:0];
			end

			if (context_we) begin
				context_word[31:23] <= wdata[31:23]; // PTEBase
			end

			// The faulting VPN2 comes last so it overrides a TLBR in the same cycle
			if (tlb_fault_load) begin
				context_word[22:4] <= except_extra[31:13];
				entry_hi[31:13] <= except_extra[31:13];
			end
		end
	end

	assign asid = entry_hi[7:0];

	assign tlbw_vpn2 = entry_hi[31:13];
	assign tlbw_asid = entry_hi[7:0];
	assign tlbw_g = entry_lo0[0] & entry_lo1[0];
	assign tlbw_pfn0 = entry_lo0[29:6];
	assign tlbw_c0 = entry_lo0[5:3];
	assign tlbw_d0 = entry_lo0[2];
	assign tlbw_v0 = entry_lo0[1];
	assign tlbw_pfn1 = entry_lo1[29:6];
	assign tlbw_c1 = entry_lo1[5:3];
	assign tlbw_d1 = entry_lo1[2];
	assign tlbw_v1 = entry_lo1[1];

endmodule

/* logic/cp0_top.sv */
`timescale 1ns/100ps

module cp0_top import cp0_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        stall,
	input  logic        we,
	input  logic [4:0]  waddr,
	input  logic [2:0]  wsel,
	input  logic [31:0] wdata,
	input  logic [4:0]  raddr,
	input  logic [2:0]  rsel,
	input  logic        except_valid,
	input  logic        except_eret,
	input  logic        except_delayslot,
	input  logic [4:0]  except_code,
	input  logic [31:0] except_pc,
	input  logic [31:0] except_extra,
	input  logic [7:0]  interrupt_flag,
	input  logic        tlbr_req,
	input  logic [18:0] tlbr_vpn2,
	input  logic [7:0]  tlbr_asid,
	input  logic        tlbr_g,
	input  logic [23:0] tlbr_pfn0,
	input  logic [2:0]  tlbr_c0,
	input  logic        tlbr_d0,
	input  logic        tlbr_v0,
	input  logic [23:0] tlbr_pfn1,
	input  logic [2:0]  tlbr_c1,
	input  logic        tlbr_d1,
	input  logic        tlbr_v1,
	input  logic        tlbp_req,
	input  logic [31:0] tlbp_res,
	input  logic        tlbwr_req,
	output logic [31:0] rdata,
	output cp0_status_u status,
	output cp0_cause_u  cause,
	output logic        timer_int,
	output logic [7:0]  asid,
	output logic        user_mode,
	output logic        kseg0_uncached,
	output logic [18:0] tlbw_vpn2,
	output logic [7:0]  tlbw_asid,
	output logic        tlbw_g,
	output logic [23:0] tlbw_pfn0,
	output logic [2:0]  tlbw_c0,
	output logic        tlbw_d0,
	output logic        tlbw_v0,
	output logic [23:0] tlbw_pfn1,
	output logic [2:0]  tlbw_c1,
	output logic        tlbw_d1,
	output logic        tlbw_v1
);

	logic [31:0] mtc0_wdata;
	logic [31:0] index;
	logic [31:0] random;
	logic [31:0] entry_lo0;
	logic [31:0] entry_lo1;
	logic [31:0] context_word;
	logic [31:0] wired;
	logic [31:0] bad_vaddr;
	logic [31:0] count;
	logic [31:0] entry_hi;
	logic [31:0] compare;
	logic [31:0] epc;
	logic        index_we;
	logic        entry_lo0_we;
	logic        entry_lo1_we;
	logic        context_we;
	logic        wired_we;
	logic        count_we;
	logic        entry_hi_we;
	logic        compare_we;
	logic        status_we;
	logic        cause_we;
	logic        epc_we;
	logic        except_take;
	logic        eret_take;
	logic        badvaddr_load;
	logic        tlb_fault_load;
	logic        tlbr_take;
	logic        tlbp_take;

	cp0_access_ctrl cp0_access_ctrl_inst (
		.clk            (clk),
		.rst            (rst),
		.stall          (stall),
		.we             (we),
		.waddr          (waddr),
		.wsel           (wsel),
		.wdata_in       (wdata),
		.raddr          (raddr),
		.rsel           (rsel),
		.except_valid   (except_valid),
		.except_eret    (except_eret),
		.except_code    (except_code),
		.tlbr_req       (tlbr_req),
		.tlbp_req       (tlbp_req),
		.index          (index),
		.random         (random),
		.entry_lo0      (entry_lo0),
		.entry_lo1      (entry_lo1),
		.context_word   (context_word),
		.wired          (wired),
		.bad_vaddr      (bad_vaddr),
		.count          (count),
		.entry_hi       (entry_hi),
		.compare        (compare),
		.epc            (epc),
		.status         (status),
		.cause          (cause),
		.index_we       (index_we),
		.entry_lo0_we   (entry_lo0_we),
		.entry_lo1_we   (entry_lo1_we),
		.context_we     (context_we),
		.wired_we       (wired_we),
		.count_we       (count_we),
		.entry_hi_we    (entry_hi_we),
		.compare_we     (compare_we),
		.status_we      (status_we),
		.cause_we       (cause_we),
		.epc_we         (epc_we),
		.except_take    (except_take),
		.eret_take      (eret_take),
		.badvaddr_load  (badvaddr_load),
		.tlb_fault_load (tlb_fault_load),
		.tlbr_take      (tlbr_take),
		.tlbp_take      (tlbp_take),
		.wdata          (mtc0_wdata),
		.rdata          (rdata),
		.kseg0_uncached (kseg0_uncached)
	);

	cp0_status_cause cp0_status_cause_inst (
		.clk              (clk),
		.rst              (rst),
		.status_we        (status_we),
		.cause_we         (cause_we),
		.epc_we           (epc_we),
		.except_take      (except_take),
		.eret_take        (eret_take),
		.badvaddr_load    (badvaddr_load),
		.except_delayslot (except_delayslot),
		.except_code      (except_code),
		.except_pc        (except_pc),
		.except_extra     (except_extra),
		.wdata            (mtc0_wdata),
		.interrupt_flag   (interrupt_flag),
		.status           (status),
		.cause            (cause),
		.epc              (epc),
		.bad_vaddr        (bad_vaddr),
		.user_mode        (user_mode)
	);

	cp0_timer cp0_timer_inst (
		.clk        (clk),
		.rst        (rst),
		.count_we   (count_we),
		.compare_we (compare_we),
		.wdata      (mtc0_wdata),
		.count      (count),
		.compare    (compare),
		.timer_int  (timer_int)
	);

	cp0_tlb_regs cp0_tlb_regs_inst (
		.clk            (clk),
		.rst            (rst),
		.index_we       (index_we),
		.entry_lo0_we   (entry_lo0_we),
		.entry_lo1_we   (entry_lo1_we),
		.context_we     (context_we),
		.wired_we       (wired_we),
		.entry_hi_we    (entry_hi_we),
		.tlbr_take      (tlbr_take),
		.tlbp_take      (tlbp_take),
		.tlbwr_req      (tlbwr_req),
		.tlb_fault_load (tlb_fault_load),
		.wdata          (mtc0_wdata),
		.except_extra   (except_extra),
		.tlbp_res       (tlbp_res),
		.tlbr_vpn2      (tlbr_vpn2),
		.tlbr_asid      (tlbr_asid),
		.tlbr_g         (tlbr_g),
		.tlbr_pfn0      (tlbr_pfn0),
		.tlbr_c0        (tlbr_c0),
		.tlbr_d0        (tlbr_d0),
		.tlbr_v0        (tlbr_v0),
		.tlbr_pfn1      (tlbr_pfn1),
		.tlbr_c1        (tlbr_c1),
		.tlbr_d1        (tlbr_d1),
		.tlbr_v1        (tlbr_v1),
		.index          (index),
		.random         (random),
		.entry_lo0      (entry_lo0),
		.entry_lo1      (entry_lo1),
		.context_word   (context_word),
		.wired          (wired),
		.entry_hi       (entry_hi),
		.asid           (asid),
		.tlbw_vpn2      (tlbw_vpn2),
		.tlbw_asid      (tlbw_asid),
		.tlbw_g         (tlbw_g),
		.tlbw_pfn0      (tlbw_pfn0),
		.tlbw_c0        (tlbw_c0),
		.tlbw_d0        (tlbw_d0),
		.tlbw_v0        (tlbw_v0),
		.tlbw_pfn1      (tlbw_pfn1),
		.tlbw_c1        (tlbw_c1),
		.tlbw_d1        (tlbw_d1),
		.tlbw_v1        (tlbw_v1)
	);

endmodule

/* test/cp0_tb.sv */
`timescale 1ns/100ps
`include "cp0_consts.svh"

module cp0_tb import cp0_pkg::*; ();

	logic        clk;
	logic        rst;
	logic        stall;
	logic        we;
	logic [4:0]  waddr;
	logic [2:0]  wsel;
	logic [31:0] wdata;
	logic [4:0]  raddr;
	logic [2:0]  rsel;
	logic        except_valid;
	logic        except_eret;
	logic        except_delayslot;
	logic [4:0]  except_code;
	logic [31:0] except_pc;
	logic [31:0] except_extra;
	logic [7:0]  interrupt_flag;
	logic        tlbr_req;
	logic [18:0] tlbr_vpn2;
	logic [7:0]  tlbr_asid;
	logic        tlbr_g;
	logic [23:0] tlbr_pfn0;
	logic [2:0]  tlbr_c0;
	logic        tlbr_d0;
	logic        tlbr_v0;
	logic [23:0] tlbr_pfn1;
	logic [2:0]  tlbr_c1;
	logic        tlbr_d1;
	logic        tlbr_v1;
	logic        tlbp_req;
	logic [31:0] tlbp_res;
	logic        tlbwr_req;
	logic [31:0] rdata;
	cp0_status_u status;
	cp0_cause_u  cause;
	logic        timer_int;
	logic [7:0]  asid;
	logic        user_mode;
	logic        kseg0_uncached;
	logic [18:0] tlbw_vpn2;
	logic [7:0]  tlbw_asid;
	logic        tlbw_g;
	logic [23:0] tlbw_pfn0;
	logic [2:0]  tlbw_c0;
	logic        tlbw_d0;
	logic        tlbw_v0;
	logic [23:0] tlbw_pfn1;
	logic [2:0]  tlbw_c1;
	logic        tlbw_d1;
	logic        tlbw_v1;

	integer      seed;
	integer      fd;
	integer      line_no;
	integer      code;
	string       op;
	string       rest;
	string       name;
	logic [31:0] addr;
	logic [31:0] data;
	logic [31:0] expected;

	cp0_top cp0_top_inst (.*);

	always #10 clk = ~clk; // 20 ns period

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_word(input string test, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			abort_run($sformatf("[ERROR] %s: expected %h, actual %h", test, exp, act));
		end
	endtask

	task automatic check_status(input string test, input cp0_status_u exp, input cp0_status_u act);
		if (act.raw !== exp.raw) begin
			abort_run($sformatf("[ERROR] %s: expected status %h, actual %h", test, exp.raw,
				act.raw));
		end
	endtask

	task automatic check_cause(input string test, input cp0_cause_u exp, input cp0_cause_u act);
		if (act.raw !== exp.raw) begin
			abort_run($sformatf("[ERROR] %s: expected cause %h, actual %h", test, exp.raw,
				act.raw));
		end
	endtask

	task automatic check_bit(input string test, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("[ERROR] %s: expected %b, actual %b", test, exp, act));
		end
	endtask

	// Drops last cycle's strobes and puts noise on the unused write data
	task automatic clear_requests();
		we <= 1'b0;
		except_valid <= 1'b0;
		except_eret <= 1'b0;
		except_delayslot <= 1'b0;
		tlbr_req <= 1'b0;
		tlbp_req <= 1'b0;
		tlbwr_req <= 1'b0;
		wdata <= $random(seed);
	endtask

	task automatic mtc0_write(input logic [4:0] reg_num, input logic [31:0] value);
		@(posedge clk);
		clear_requests();
		we <= 1'b1;
		waddr <= reg_num;
		wsel <= 3'd0;
		wdata <= value;
	endtask

	task automatic mfc0_read(input logic [4:0] reg_num, input logic [2:0] sel,
		input logic [31:0] exp, input string test);
		@(posedge clk);
		clear_requests();
		raddr <= reg_num;
		rsel <= sel;
		@(posedge clk); // rdata is registered
		@(negedge clk);
		check_word(test, exp, rdata);
	endtask

	// Flags: bit 6 selects ERET, bit 5 marks a delay slot, bits 4:0 hold the code
	task automatic raise_exception(input logic [6:0] flags, input logic [31:0] pc,
		input logic [31:0] extra);
		@(posedge clk);
		clear_requests();
		except_valid <= 1'b1;
		except_eret <= flags[6];
		except_delayslot <= flags[5];
		except_code <= flags[4:0];
		except_pc <= pc;
		except_extra <= extra;
	endtask

	task automatic tlb_read_check(input string test);
		logic [31:0] rnd;
		logic [18:0] vpn2;
		logic [7:0]  asid_v;
		logic        g;
		logic [23:0] pfn0;
		logic [23:0] pfn1;
		logic [4:0]  cdv0;
		logic [4:0]  cdv1;
		rnd = $random(seed);
		vpn2 = rnd[18:0];
		asid_v = rnd[26:19];
		g = rnd[27];
		rnd = $random(seed);
		pfn0 = rnd[23:0];
		cdv0 = rnd[28:24]; // C, D and V of the even page
		rnd = $random(seed);
		pfn1 = rnd[23:0];
		cdv1 = rnd[28:24];
		@(posedge clk);
		clear_requests();
		tlbr_req <= 1'b1;
		tlbr_vpn2 <= vpn2;
		tlbr_asid <= asid_v;
		tlbr_g <= g;
		tlbr_pfn0 <= pfn0;
		{tlbr_c0, tlbr_d0, tlbr_v0} <= cdv0;
		tlbr_pfn1 <= pfn1;
		{tlbr_c1, tlbr_d1, tlbr_v1} <= cdv1;
		mfc0_read(`CP0_REG_ENTRY_HI, 3'd0, {vpn2, 5'd0, asid_v}, {test, " entry_hi"});
		mfc0_read(`CP0_REG_ENTRY_LO0, 3'd0, {2'b00, pfn0, cdv0, g}, {test, " entry_lo0"});
		mfc0_read(`CP0_REG_ENTRY_LO1, 3'd0, {2'b00, pfn1, cdv1, g}, {test, " entry_lo1"});
		check_word({test, " tlbw_vpn2"}, {13'd0, vpn2}, {13'd0, tlbw_vpn2});
		check_word({test, " tlbw_asid"}, {24'd0, asid_v}, {24'd0, tlbw_asid});
		check_word({test, " asid"}, {24'd0, asid_v}, {24'd0, asid});
		check_bit({test, " tlbw_g"}, g, tlbw_g);
		check_word({test, " tlbw_pfn0"}, {8'd0, pfn0}, {8'd0, tlbw_pfn0});
		check_word({test, " tlbw_pfn1"}, {8'd0, pfn1}, {8'd0, tlbw_pfn1});
		check_word({test, " tlbw cdv0"}, {27'd0, cdv0}, {27'd0, tlbw_c0, tlbw_d0, tlbw_v0});
		check_word({test, " tlbw cdv1"}, {27'd0, cdv1}, {27'd0, tlbw_c1, tlbw_d1, tlbw_v1});
	endtask

	task automatic output_check(input logic [2:0] selector, input logic [31:0] exp,
		input string test);
		@(posedge clk);
		clear_requests();
		@(negedge clk);
		case (selector)
			3'd0: check_bit(test, exp[0], timer_int);
			3'd1: check_bit(test, exp[0], user_mode);
			3'd2: check_bit(test, exp[0], kseg0_uncached);
			3'd3: check_word(test, exp, {24'd0, asid});
			3'd4: check_status(test, cp0_status_u'(exp), status);
			3'd5: check_cause(test, cp0_cause_u'(exp), cause);
			default: abort_run($sformatf("%s selects an output that does not exist", test));
		endcase
	endtask

	task automatic wait_timer(input logic [31:0] limit, input string test);
		integer cycles;
		@(posedge clk);
		clear_requests();
		cycles = 0;
		@(negedge clk);
		while (timer_int !== 1'b1) begin
			if (cycles >= limit) begin
				abort_run($sformatf("%s: timer_int did not rise within %0d cycles", test, limit));
			end else begin
				@(negedge clk);
				cycles = cycles + 1;
			end
		end
	endtask

	initial begin
		seed = 81572;
		clk = 1'b0;
		rst = 1'b1;
		stall = 1'b0;
		we = 1'b0;
		waddr = 5'd0;
		wsel = 3'd0;
		wdata = 32'd0;
		raddr = 5'd0;
		rsel = 3'd0;
		except_valid = 1'b0;
		except_eret = 1'b0;
		except_delayslot = 1'b0;
		except_code = 5'd0;
		except_pc = 32'd0;
		except_extra = 32'd0;
		interrupt_flag = 8'd0;
		tlbr_req = 1'b0;
		{tlbr_vpn2, tlbr_asid, tlbr_g} = 28'd0;
		{tlbr_pfn0, tlbr_c0, tlbr_d0, tlbr_v0} = 29'd0;
		{tlbr_pfn1, tlbr_c1, tlbr_d1, tlbr_v1} = 29'd0;
		tlbp_req = 1'b0;
		tlbp_res = 32'd0;
		tlbwr_req = 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		fd = $fopen("test/cp0_stimulus.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open test/cp0_stimulus.txt");
		end
		line_no = 0;
		while ($fscanf(fd, "%s", op) == 1) begin
			line_no = line_no + 1;
			if (op[0] == "#") begin
				code = $fgets(rest, fd); // Comment line
			end else begin
				code = $fscanf(fd, "%h %h %h", addr, data, expected);
				if (code != 3) begin
					abort_run($sformatf("Line %0d of the stimulus file is incomplete", line_no));
				end
				name = $sformatf("line %0d %s %h", line_no, op, addr[7:0]);
				case (op[0])
					"W": mtc0_write(addr[4:0], data);
					"R": mfc0_read(addr[4:0], data[2:0], expected, name);
					"E": raise_exception(addr[6:0], data, expected);
					"T": tlb_read_check(name);
					"C": output_check(addr[2:0], expected, name);
					"A": wait_timer(data, name);
					"P": begin
						@(posedge clk);
						clear_requests();
						tlbp_req <= 1'b1;
						tlbp_res <= data;
					end
					"X": begin
						@(posedge clk);
						clear_requests();
						tlbwr_req <= 1'b1;
					end
					"S": begin
						@(posedge clk);
						clear_requests();
						stall <= data[0];
					end
					"I": begin
						@(posedge clk);
						clear_requests();
						interrupt_flag <= data[7:0];
					end
					default: abort_run($sformatf("Unknown operation %s on line %0d", op, line_no));
				endcase
			end
		end
		$fclose(fd);
		$display("Done: no errors");
		$finish;
	end

endmodule

/* test/cp0_stimulus.txt */
# op addr data expected, all hex. R: data is sel. E: addr bit 6 ERET, bit 5 delay slot, 4:0 code,
# data is pc, expected is the bad address. C: addr picks timer_int user_mode kseg0 asid status cause
R 00 0 00000000
R 01 0 0000000f
R 02 0 00000000
R 03 0 00000000
R 04 0 00000000
R 06 0 00000000
R 08 0 00000000
R 0a 0 00000000
R 0b 0 00000000
R 0c 0 00400004
R 0d 0 00000000
R 0e 0 00000000
R 0f 0 00018000
R 10 0 80000083
R 05 0 00000000
R 1f 0 00000000
R 0c 1 00000000
C 0 0 00000000
C 1 0 00000000
C 2 0 00000000
# write masks
W 00 ffffffff 0
R 00 0 0000000f
W 02 ffffffff 0
R 02 0 3fffffff
W 03 ffffffff 0
R 03 0 3fffffff
W 04 ffffffff 0
R 04 0 ff800000
W 06 ffffffff 0
R 06 0 0000000f
W 0a ffffffff 0
R 0a 0 ffffe0ff
C 3 0 000000ff
W 0b ffffffff 0
R 0b 0 ffffffff
W 09 00001000 0
R 09 0 00001000
W 0e ffffffff 0
R 0e 0 ffffffff
W 0d ffffffff 0
R 0d 0 00800300
W 0f ffffffff 0
R 0f 0 00018000
W 10 ffffffff 0
R 10 0 80000087
W 10 00000002 0
C 2 0 00000001
W 0c ffffffff 0
R 0c 0 1040ff17
W 0c 00000010 0
C 1 0 00000001
S 0 1 0
W 0e 12345678 0
S 0 0 0
R 0e 0 ffffffff
# exceptions
E 22 bfc00104 12345abc
C 4 0 00000012
C 5 0 80800308
R 0e 0 bfc00100
R 08 0 12345abc
R 04 0 ff891a20
R 0a 0 123440ff
I 0 ff 0
C 5 0 8080ff08
E 04 80001000 0000dead
R 0d 0 8080ff10
R 0e 0 bfc00100
R 08 0 0000dead
R 04 0 ff891a20
W 0c 00400006 0
E 40 0 0
C 4 0 00400002
E 40 0 0
C 4 0 00400000
# TLB operations
T 0 0 0
P 0 80000000 0
R 00 0 80000000
P 0 00000005 0
R 00 0 00000005
W 06 00000004 0
R 01 0 0000000f
X 0 0 0
R 01 0 00000004
X 0 0 0
R 01 0 00000005
# timer
W 0b 80000100 0
W 09 800000f8 0
C 0 0 00000000
A 0 40 0
W 0b 00000000 0
C 0 0 00000000

/* Makefile */
VERILATOR ?= verilator
TOP ?= cp0_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_MSG ?= Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* project.f */
+incdir+include
logic/cp0_pkg.sv
logic/cp0_access_ctrl.sv
logic/cp0_status_cause.sv
logic/cp0_timer.sv
logic/cp0_tlb_regs.sv
logic/cp0_top.sv
test/cp0_tb.sv
